// File: hw/ColorPkg.sv
/*
 * Pixel format shared by the fragment pipeline.
 * Defines the default channel width, the position of each channel inside a
 * 32-bit RGBA8888 pixel and the packed color struct that carries a pixel.
 */
`default_nettype none

package ColorPkg;

    // Width of one color channel in bits
    localparam int SubPixelWidth = 8;

    // Bit offsets of the channels inside a packed pixel, red in the top byte
    localparam int ColorRPos = 24;
    localparam int ColorGPos = 16;
    localparam int ColorBPos = 8;
    localparam int ColorAPos = 0;

    // One RGBA pixel, red first so the field order matches the bit offsets above
    typedef struct packed {
        logic [SubPixelWidth-1:0] r;
        logic [SubPixelWidth-1:0] g;
        logic [SubPixelWidth-1:0] b;
        logic [SubPixelWidth-1:0] a;
    } rgba_t;

endpackage

`default_nettype wire

// File: hw/FogPkg.sv
/*
 * Fog control types for the fog stage.
 * Holds the fog mode, the quasi-static fog configuration and the fragment
 * that enters the pipeline. Intensity 0 selects pure fog color, 0xFFFF the texel.
 */
`default_nettype none

package FogPkg;

    // Width of the fog factor that runs from the intensity stage into the blend
    localparam int IntensityWidth = 16;

    // Only the linear equation is implemented
    typedef enum logic {
        FOG_OFF    = 1'b0,
        FOG_LINEAR = 1'b1
    } fog_mode_t;

    // Held stable while fragments are in flight
    typedef struct packed {
        fog_mode_t        mode;
        logic [15:0]      fogEnd;
        // Unsigned Q8.8 slope of the linear equation
        logic [15:0]      fogScale;
        ColorPkg::rgba_t  fogColor;
    } fog_cfg_t;

    // A fragment as it arrives from the rasterizer
    typedef struct packed {
        logic [15:0]      depth;
        ColorPkg::rgba_t  texel;
    } fragment_t;

endpackage

`default_nettype wire

// File: hw/FogIntensity.sv
/*
 * Linear fog factor from fragment depth.
 * Two register stages. The first forms the distance to the fog end, the second
 * scales and saturates it. The configuration must not change while fragments
 * are in flight, since the scale is read in the second stage.
 */
`default_nettype none
`timescale 1ns/1ns

module FogIntensity (
    input  logic                              aclk,
    input  logic                              rstN,
    input  logic [15:0]                       depth,
    input  FogPkg::fog_cfg_t                  cfg,
    output logic [FogPkg::IntensityWidth-1:0] intensity
);
    import FogPkg::*;

    // First stage registers
    logic [15:0]               distQ;
    logic                      beyondEndQ;
    fog_mode_t                 modeQ;

    // Second stage arithmetic
    logic [31:0]               product;
    logic [23:0]               scaled;
    logic [IntensityWidth-1:0] linear;

    // Distance from the fragment to the point where fog becomes opaque
    // The difference wraps for depths past the end, which the flag then overrides
    always_ff @(posedge aclk) begin
        distQ      <= cfg.fogEnd - depth;
        beyondEndQ <= (depth >= cfg.fogEnd);
        modeQ      <= cfg.mode;
    end

    // Scale is Q8.8 so the product carries eight fractional bits
    always_comb begin
        product = distQ * cfg.fogScale;
        scaled  = product[31:8];
        // Anything above 16 integer bits is clear texel and clips to full scale
        if (|scaled[23:16]) begin
            linear = '1;
        end else begin
            linear = scaled[15:0];
        end
    end

    // Fog off always passes the texel untouched
    always_ff @(posedge aclk) begin
        if (modeQ == FOG_OFF) begin
            intensity <= '1;
        end else if (beyondEndQ) begin
            intensity <= '0;
        end else begin
            intensity <= linear;
        end
    end

    // With fog disabled the factor must be full scale once the mode reaches the output
    fogOffFullScale: assert property (
        @(posedge aclk) disable iff (!rstN)
        (cfg.mode == FOG_OFF) |-> ##2 (intensity == '1)
    ) else $error("FogIntensity produced a partial factor in FOG_OFF");

endmodule

`default_nettype wire

// File: hw/ColorInterpolator.sv
/*
 * Per-channel linear blend of two colors.
 * colorA is weighted by the intensity and colorB by its complement. The result
 * appears two cycles after the inputs and a new pair is accepted every cycle.
 */
`default_nettype none
`timescale 1ns/1ns

module ColorInterpolator #(
    parameter int SUB_PIXEL_WIDTH = 8
) (
    input  logic            aclk,
    input  logic            rstN,
    input  logic [15:0]     intensity,
    input  ColorPkg::rgba_t colorA,
    input  ColorPkg::rgba_t colorB,
    output ColorPkg::rgba_t mixedColor
);
    import ColorPkg::*;

    localparam int NumChannels = 4;
    // A channel times a 17-bit weight
    localparam int ProductWidth = SUB_PIXEL_WIDTH + 17;

    localparam int ChannelPos [NumChannels] = '{ColorRPos, ColorGPos, ColorBPos, ColorAPos};

    // Weight runs from 0 to 65536 so that full intensity selects colorA exactly
    logic [16:0]                  weight;
    logic [16:0]                  weightInv;

    logic [SUB_PIXEL_WIDTH-1:0]   chA [NumChannels];
    logic [SUB_PIXEL_WIDTH-1:0]   chB [NumChannels];
    logic [ProductWidth-1:0]      prodAQ [NumChannels];
    logic [ProductWidth-1:0]      prodBQ [NumChannels];
    logic [ProductWidth-1:0]      sum [NumChannels];
    logic [SUB_PIXEL_WIDTH-1:0]   chOutQ [NumChannels];
    logic [NumChannels-1:0]       sumOverflow;

    always_comb begin
        // Adding the top bit maps 0xFFFF onto 65536
        weight    = {1'b0, intensity} + {16'd0, intensity[15]};
        weightInv = 17'h10000 - weight;
        for (int i = 0; i < NumChannels; i++) begin
            chA[i] = colorA[ChannelPos[i] +: SUB_PIXEL_WIDTH];
            chB[i] = colorB[ChannelPos[i] +: SUB_PIXEL_WIDTH];
        end
    end

    // First stage holds both weighted products of every channel
    always_ff @(posedge aclk) begin
        for (int i = 0; i < NumChannels; i++) begin
            prodAQ[i] <= chA[i] * weight;
            prodBQ[i] <= chB[i] * weightInv;
        end
    end

    // The sum is a weighted mean, so bits above 16 hold the blended channel
    always_comb begin
        for (int i = 0; i < NumChannels; i++) begin
            sum[i]         = prodAQ[i] + prodBQ[i];
            sumOverflow[i] = sum[i][ProductWidth-1];
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < NumChannels; i++) begin
            chOutQ[i] <= sum[i][16 +: SUB_PIXEL_WIDTH];
        end
    end

    always_comb begin
        mixedColor = '0;
        for (int i = 0; i < NumChannels; i++) begin
            mixedColor[ChannelPos[i] +: SUB_PIXEL_WIDTH] = chOutQ[i];
        end
    end

    // Weights that do not add up to 65536 would push a channel past its width
    blendInRange: assert property (
        @(posedge aclk) disable iff (!rstN)
        sumOverflow == '0
    ) else $error("ColorInterpolator channel sum exceeds the channel width");

endmodule

`default_nettype wire

// File: hw/Fog.sv
/*
 * Applies a precomputed fog factor to a texel.
 * RGB moves toward the fog color as the intensity falls. Alpha is never fogged,
 * so the texel alpha is delayed alongside the blend and put back at the output.
 */
`default_nettype none
`timescale 1ns/1ns

module Fog #(
    parameter int SUB_PIXEL_WIDTH = 8
) (
    input  logic                              aclk,
    input  logic                              rstN,
    input  logic [FogPkg::IntensityWidth-1:0] intensity,
    input  ColorPkg::rgba_t                   texelColor,
    input  ColorPkg::rgba_t                   fogColor,
    output ColorPkg::rgba_t                   color
);
    import ColorPkg::*;

    rgba_t                       mixedColor;
    logic [SUB_PIXEL_WIDTH-1:0]  alphaQ [2];

    // Same depth as the interpolator so alpha lines up with its fragment
    always_ff @(posedge aclk) begin
        alphaQ[0] <= texelColor[ColorAPos +: SUB_PIXEL_WIDTH];
        alphaQ[1] <= alphaQ[0];
    end

    // Texel is colorA, so full intensity keeps it
    ColorInterpolator #(
        .SUB_PIXEL_WIDTH (SUB_PIXEL_WIDTH)
    ) fogInterpolator (
        .aclk       (aclk),
        .rstN       (rstN),
        .intensity  (intensity),
        .colorA     (texelColor),
        .colorB     (fogColor),
        .mixedColor (mixedColor)
    );

    always_comb begin
        color = mixedColor;
        // Blended alpha is dropped
        color[ColorAPos +: SUB_PIXEL_WIDTH] = alphaQ[1];
    end

endmodule

`default_nettype wire

// File: hw/FogPipeline.sv
/*
 * Fog stage of the fragment pipeline.
 * Computes the fog factor from depth and blends the texel toward the fog color.
 * Fixed four-cycle latency, one fragment per cycle and no back-pressure.
 */
`default_nettype none
`timescale 1ns/1ns

module FogPipeline #(
    parameter int SUB_PIXEL_WIDTH = ColorPkg::SubPixelWidth
) (
    input  logic                aclk,
    input  logic                rstN,
    input  logic                inVld,
    input  FogPkg::fragment_t   inFrag,
    input  FogPkg::fog_cfg_t    cfg,
    output logic                outVld,
    output ColorPkg::rgba_t     outColor
);
    import ColorPkg::*;
    import FogPkg::*;

    logic [IntensityWidth-1:0] intensity;

    // Texel and valid wait here while the factor is computed
    rgba_t                     texelQ [2];
    logic [1:0]                vldQ;
    // Valid waits again while the blend runs
    logic [1:0]                outVldQ;

    FogIntensity intensity0 (
        .aclk      (aclk),
        .rstN      (rstN),
        .depth     (inFrag.depth),
        .cfg       (cfg),
        .intensity (intensity)
    );

    // Payload carries no reset
    always_ff @(posedge aclk) begin
        texelQ[0] <= inFrag.texel;
        texelQ[1] <= texelQ[0];
    end

    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            vldQ    <= '0;
            outVldQ <= '0;
        end else begin
            vldQ    <= {vldQ[0], inVld};
            outVldQ <= {outVldQ[0], vldQ[1]};
        end
    end

    // Fog color is quasi-static so it is taken straight from the configuration
    Fog #(
        .SUB_PIXEL_WIDTH (SUB_PIXEL_WIDTH)
    ) fog0 (
        .aclk       (aclk),
        .rstN       (rstN),
        .intensity  (intensity),
        .texelColor (texelQ[1]),
        .fogColor   (cfg.fogColor),
        .color      (outColor)
    );

    assign outVld = outVldQ[1];

    // Every accepted fragment leaves exactly four cycles later and nothing else does
    vldLatency: assert property (
        @(posedge aclk) disable iff (!rstN)
        inVld |-> ##4 outVld
    ) else $error("FogPipeline lost a fragment");

    noSpuriousVld: assert property (
        @(posedge aclk) disable iff (!rstN)
        outVld |-> $past(inVld, 4)
    ) else $error("FogPipeline produced an output without an input");

endmodule

`default_nettype wire

// File: testbench/FogPipelineTb.sv
/*
 * Self-checking testbench for the fog pipeline.
 * Drives fragments and fog configurations, predicts each output color with a
 * reference model and lets concurrent assertions compare the DUT against it.
 */
`default_nettype none
`timescale 1ns/1ns

module FogPipelineTb;
    import ColorPkg::*;
    import FogPkg::*;

    localparam int MaxCycles = 2000;
    localparam int NumTests  = 6;

    logic        aclk;
    logic        rstN;
    logic        inVld;
    fragment_t   inFrag;
    fog_cfg_t    cfg;
    logic        outVld;
    rgba_t       outColor;

    logic [31:0] rngState;
    int          errCount;
    int          checkCount;
    int          cycleCount;
    // Expected colors in arrival order, head is moved to expColor when outVld shows up
    rgba_t       expQ [$];
    rgba_t       expColor;

    FogPipeline #(
        .SUB_PIXEL_WIDTH (SubPixelWidth)
    ) dut0 (
        .aclk     (aclk),
        .rstN     (rstN),
        .inVld    (inVld),
        .inFrag   (inFrag),
        .cfg      (cfg),
        .outVld   (outVld),
        .outColor (outColor)
    );

    always #10 aclk = ~aclk;

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic rgba_t randColor();
        logic [31:0] r;
        r = nextRand();
        return rgba_t'(r);
    endfunction

    // Weighted mean of two channel values, w out of 65536 goes to a
    function automatic logic [7:0] mixChannel(input logic [7:0] a, input logic [7:0] b,
                                              input longint unsigned w);
        longint unsigned s;
        s = 64'(a) * w + 64'(b) * (64'd65536 - w);
        return 8'(s >> 16);
    endfunction

    // Expected pixel for one fragment under configuration c
    function automatic rgba_t refColor(input logic [15:0] depth, input rgba_t texel,
                                       input fog_cfg_t c);
        longint unsigned lin;
        longint unsigned fac;
        longint unsigned w;
        rgba_t           res;
        if (c.mode == FOG_OFF) begin
            fac = 64'd65535;
        end else if (depth >= c.fogEnd) begin
            fac = 64'd0;
        end else begin
            // Scale is Q8.8, so drop eight fraction bits before clamping
            lin = ((64'(c.fogEnd) - 64'(depth)) * 64'(c.fogScale)) >> 8;
            fac = (lin > 64'd65535) ? 64'd65535 : lin;
        end
        w     = fac + (fac >> 15);
        res.r = mixChannel(texel.r, c.fogColor.r, w);
        res.g = mixChannel(texel.g, c.fogColor.g, w);
        res.b = mixChannel(texel.b, c.fogColor.b, w);
        res.a = texel.a;
        return res;
    endfunction

    // Configuration only changes while nothing is in flight
    task automatic applyCfg(input fog_cfg_t c);
        @(posedge aclk);
        inVld <= 1'b0;
        cfg   <= c;
    endtask

    task automatic sendFrag(input logic [15:0] depth, input rgba_t texel);
        @(posedge aclk);
        inVld        <= 1'b1;
        inFrag.depth <= depth;
        inFrag.texel <= texel;
        expQ.push_back(refColor(depth, texel, cfg));
    endtask

    task automatic skipCycle();
        @(posedge aclk);
        inVld        <= 1'b0;
        inFrag.texel <= randColor();
    endtask

    // Waits until every expected color was consumed and its check has run
    task automatic drain();
        @(posedge aclk);
        inVld <= 1'b0;
        while (expQ.size() != 0) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk);
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("Test %-28s %0d errors", name, errCount - errBefore);
    endtask

    // outVld changes on the rising edge, so the head is taken at the falling edge
    always @(negedge aclk) begin
        if (rstN && outVld) begin
            if (expQ.size() == 0) begin
                errCount++;
                $display("Output at %0t arrived with no fragment outstanding", $time);
            end else begin
                expColor = expQ.pop_front();
                checkCount++;
            end
        end
    end

    colorMatch: assert property (
        @(posedge aclk) disable iff (!rstN)
        outVld |-> (outColor == expColor)
    ) else begin
        errCount++;
        $display("ERROR at %0t: outColor %h, expected %h", $time, $sampled(outColor), expColor);
    end

    resetQuiet: assert property (
        @(posedge aclk)
        !rstN |-> !outVld
    ) else begin
        errCount++;
        $display("outVld was high during reset at %0t", $time);
    end

    vldFollows: assert property (
        @(posedge aclk) disable iff (!rstN)
        inVld |-> ##4 outVld
    ) else begin
        errCount++;
        $display("An accepted fragment had no outVld four cycles later, at %0t", $time);
    end

    vldOrigin: assert property (
        @(posedge aclk) disable iff (!rstN)
        outVld |-> $past(inVld, 4)
    ) else begin
        errCount++;
        $display("outVld rose at %0t without an input four cycles earlier", $time);
    end

    // Hard limit on the run length, about four times the stimulus
    always @(posedge aclk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        fog_cfg_t    c;
        logic [31:0] r;
        int          errBefore;
        aclk       = 1'b0;
        rstN       = 1'b0;
        inVld      = 1'b0;
        inFrag     = '0;
        cfg        = '0;
        expColor   = '0;
        rngState   = 32'h2c8c_0ef9;
        errCount   = 0;
        checkCount = 0;
        cycleCount = 0;

        errBefore = errCount;
        repeat (5) @(posedge aclk);
        rstN <= 1'b1;
        repeat (20) skipCycle();
        reportTest("idle through reset", errBefore);

        // Fog off must give back the texel bit for bit
        errBefore = errCount;
        r          = nextRand();
        c.mode     = FOG_OFF;
        c.fogEnd   = r[15:0];
        c.fogScale = r[31:16];
        c.fogColor = randColor();
        applyCfg(c);
        for (int i = 0; i < 30; i++) begin
            r = nextRand();
            sendFrag(r[15:0], randColor());
        end
        drain();
        reportTest("fog off passes texel", errBefore);

        // Fragments at or past the end are fully fogged, starting exactly at the end
        errBefore = errCount;
        c.mode     = FOG_LINEAR;
        c.fogEnd   = 16'h3000;
        c.fogScale = 16'h0100;
        c.fogColor = randColor();
        applyCfg(c);
        sendFrag(16'h3000, randColor());
        for (int i = 0; i < 30; i++) begin
            r = nextRand();
            sendFrag(16'h3000 + {4'd0, r[11:0]}, randColor());
        end
        drain();
        reportTest("beyond fog end", errBefore);

        // Near fragments with a steep scale clip to full intensity
        errBefore = errCount;
        c.fogEnd   = 16'h8000;
        c.fogScale = 16'h0400;
        c.fogColor = randColor();
        applyCfg(c);
        for (int i = 0; i < 30; i++) begin
            r = nextRand();
            sendFrag({8'd0, r[7:0]}, randColor());
        end
        drain();
        reportTest("saturated near fragments", errBefore);

        // Four bursts of fifty with a fresh configuration for each
        errBefore = errCount;
        for (int b = 0; b < 4; b++) begin
            r          = nextRand();
            c.mode     = FOG_LINEAR;
            c.fogEnd   = r[15:0];
            c.fogScale = {4'd0, r[27:16]};
            c.fogColor = randColor();
            applyCfg(c);
            for (int i = 0; i < 50; i++) begin
                r = nextRand();
                sendFrag(r[15:0], randColor());
            end
            drain();
        end
        reportTest("random back-to-back bursts", errBefore);

        // Roughly one cycle in four carries no fragment
        errBefore = errCount;
        for (int i = 0; i < 80; i++) begin
            r = nextRand();
            if (r[1:0] != 2'd0) begin
                sendFrag(r[31:16], randColor());
            end else begin
                skipCycle();
            end
        end
        drain();
        reportTest("random valid gaps", errBefore);

        $display("Tests run: %0d, output checks: %0d, errors: %0d",
                 NumTests, checkCount, errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hw/ColorPkg.sv
hw/FogPkg.sv
hw/FogIntensity.sv
hw/ColorInterpolator.sv
hw/Fog.sv
hw/FogPipeline.sv
testbench/FogPipelineTb.sv

// File: run.sh
#!/bin/sh
# Builds the fog pipeline testbench with Verilator and runs it into sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module FogPipelineTb \
    -f project.f \
    -o FogPipelineSim

./obj_dir/FogPipelineSim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
